/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_debug_io
FILELIST  ?= debug_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* button_debouncer.sv */
`timescale 1ns/1ps
`default_nettype none

module button_debouncer #(
    parameter int DEBOUNCE_LEN = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         scan_tick,
    input  logic [io_pkg::NUM_BUTTONS-1:0] btn,
    output logic [io_pkg::NUM_BUTTONS-1:0] btn_clean
);

    // sample history, newest sample in bit 0
    logic [DEBOUNCE_LEN-1:0] shift_q [io_pkg::NUM_BUTTONS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < io_pkg::NUM_BUTTONS; i++) begin
                shift_q[i] <= '0;
            end
        end else if (scan_tick) begin
            for (int i = 0; i < io_pkg::NUM_BUTTONS; i++) begin
                shift_q[i] <= {shift_q[i][DEBOUNCE_LEN-2:0], btn[i]};
            end
        end
    end

    // pressed only once every kept sample agrees
    always_comb begin
        for (int i = 0; i < io_pkg::NUM_BUTTONS; i++) begin
            btn_clean[i] = &shift_q[i];
        end
    end

endmodule

`default_nettype wire

/* clock_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_divider #(
    parameter int FAST_CLK_BIT  = 2,
    parameter int SLOW_CLK_BIT  = 20,
    parameter int SCAN_DIV_BITS = 10
) (
    input  logic clk,
    input  logic rst,
    output logic fast_clk,
    output logic slow_clk,
    output logic scan_tick
);

    // counter must reach the highest tapped bit and the scan field
    localparam int HI_CLK_BIT = (FAST_CLK_BIT > SLOW_CLK_BIT) ? FAST_CLK_BIT : SLOW_CLK_BIT;
    localparam int CNT_WIDTH  = (HI_CLK_BIT >= SCAN_DIV_BITS) ? HI_CLK_BIT + 1 : SCAN_DIV_BITS;

    logic [CNT_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + CNT_WIDTH'(1);
        end
    end

    assign fast_clk  = cnt_q[FAST_CLK_BIT];
    assign slow_clk  = cnt_q[SLOW_CLK_BIT];
    // one cycle in every 2**SCAN_DIV_BITS
    assign scan_tick = &cnt_q[SCAN_DIV_BITS-1:0];

endmodule

`default_nettype wire

/* core_clock_select.sv */
`timescale 1ns/1ps
`default_nettype none

module core_clock_select (
    input  logic clk,
    input  logic rst,
    input  logic debug_step,
    input  logic slow_clock,
    input  logic step_btn,
    input  logic fast_clk,
    input  logic slow_clk,
    output logic clk_core
);

    logic debug_q;

    // mode switch only takes effect on a clock edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            debug_q <= 1'b0;
        end else begin
            debug_q <= debug_step;
        end
    end

    always_comb begin
        if (debug_q) begin
            // single step from the debounced button
            clk_core = step_btn;
        end else if (slow_clock) begin
            clk_core = slow_clk;
        end else begin
            clk_core = fast_clk;
        end
    end

endmodule

`default_nettype wire

/* debug_io.f */
io_pkg.sv
clock_divider.sv
button_debouncer.sv
core_clock_select.sv
trace_select.sv
seg_scan_display.sv
debug_io_top.sv
debug_io_properties.sv
tb_debug_io.sv

/* debug_io_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_io_properties #(
    parameter bit SCAN_CHECKS = 1'b1,
    parameter bit STEP_CHECKS = 1'b1
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  scan_tick,
    input io_pkg::digit_enable_t an,
    input logic                  step_hold,
    input logic                  step_btn,
    input logic                  clk_core
);

    if (SCAN_CHECKS) begin : g_scan
        // exactly one digit lit
        one_digit_a: assert property (@(posedge clk) disable iff (rst) $onehot(~an))
            else $error("digit enable %b does not hold exactly one low bit", an);

        // digit only moves after a strobe
        scan_step_a: assert property (@(posedge clk) disable iff (rst)
            (an != $past(an)) |-> $past(scan_tick))
            else $error("digit enable moved without a scan strobe");
    end

    if (STEP_CHECKS) begin : g_step
        // core clock frozen in step mode while the button holds still
        step_hold_a: assert property (@(posedge clk) disable iff (rst)
            (step_hold && $past(step_hold) && $stable(step_btn)) |-> $stable(clk_core))
            else $error("core clock moved in step mode with a stable step button");
    end

endmodule

bind seg_scan_display debug_io_properties #(
    .SCAN_CHECKS (1'b1),
    .STEP_CHECKS (1'b0)
) display_props (
    .clk       (clk),
    .rst       (rst),
    .scan_tick (scan_tick),
    .an        (an),
    .step_hold (1'b0),
    .step_btn  (1'b0),
    .clk_core  (1'b0)
);

bind core_clock_select debug_io_properties #(
    .SCAN_CHECKS (1'b0),
    .STEP_CHECKS (1'b1)
) clock_props (
    .clk       (clk),
    .rst       (rst),
    .scan_tick (1'b0),
    .an        (8'hfe),
    .step_hold (debug_q),
    .step_btn  (step_btn),
    .clk_core  (clk_core)
);

`default_nettype wire

/* debug_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_io_top #(
    parameter int FAST_CLK_BIT  = 2,
    parameter int SLOW_CLK_BIT  = 20,
    parameter int SCAN_DIV_BITS = 10,
    parameter int DEBOUNCE_LEN  = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  io_pkg::panel_switch_t          switch,
    input  logic [io_pkg::NUM_BUTTONS-1:0] btn,
    input  logic                           cosim_valid,
    input  io_pkg::core_info_t             cosim_core_info,
    input  io_pkg::mem_info_t              cosim_mem_info,
    output logic                           clk_core,
    output io_pkg::seg_pattern_t           cs,
    output io_pkg::digit_enable_t          an
);

    logic                             fast_clk;
    logic                             slow_clk;
    logic                             scan_tick;
    logic [io_pkg::NUM_BUTTONS-1:0]   btn_clean;
    logic [io_pkg::DISPLAY_WIDTH-1:0] display_word;

    clock_divider #(
        .FAST_CLK_BIT  (FAST_CLK_BIT),
        .SLOW_CLK_BIT  (SLOW_CLK_BIT),
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_clock_divider (
        .clk       (clk),
        .rst       (rst),
        .fast_clk  (fast_clk),
        .slow_clk  (slow_clk),
        .scan_tick (scan_tick)
    );

    button_debouncer #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_button_debouncer (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .btn       (btn),
        .btn_clean (btn_clean)
    );

    // button 0 doubles as the single step key
    core_clock_select u_core_clock_select (
        .clk        (clk),
        .rst        (rst),
        .debug_step (switch.debug_step),
        .slow_clock (switch.slow_clock),
        .step_btn   (btn_clean[0]),
        .fast_clk   (fast_clk),
        .slow_clk   (slow_clk),
        .clk_core   (clk_core)
    );

    trace_select u_trace_select (
        .clk             (clk),
        .rst             (rst),
        .cosim_valid     (cosim_valid),
        .cosim_core_info (cosim_core_info),
        .cosim_mem_info  (cosim_mem_info),
        .field_sel       (switch.field_sel),
        .word_half       (switch.word_half),
        .display_word    (display_word)
    );

    seg_scan_display u_seg_scan_display (
        .clk          (clk),
        .rst          (rst),
        .scan_tick    (scan_tick),
        .display_word (display_word),
        .cs           (cs),
        .an           (an)
    );

endmodule

`default_nettype wire

/* io_pkg.sv */
`default_nettype none

package io_pkg;

    localparam int NUM_DIGITS    = 8;
    localparam int NUM_BUTTONS   = 5;
    localparam int TRACE_WIDTH   = 64;
    localparam int DISPLAY_WIDTH = 32;

    // active low, decimal point in bit 7
    typedef logic [7:0] seg_pattern_t;
    // active low, one bit per digit
    typedef logic [NUM_DIGITS-1:0] digit_enable_t;

    // trace word picked by the switch field, 17..31 show zero
    typedef enum logic [4:0] {
        FIELD_PC,
        FIELD_INST,
        FIELD_RS1_ID,
        FIELD_RS1_DATA,
        FIELD_RS2_ID,
        FIELD_RS2_DATA,
        FIELD_ALU,
        FIELD_MEM_ADDR,
        FIELD_MEM_WE,
        FIELD_MEM_WDATA,
        FIELD_MEM_RDATA,
        FIELD_RD_WE,
        FIELD_RD_ID,
        FIELD_RD_DATA,
        FIELD_BR_TAKEN,
        FIELD_NPC,
        FIELD_UART
    } trace_field_e;

    // commit record from the core
    typedef struct packed {
        logic [63:0] pc;
        logic [63:0] inst;
        logic [63:0] rs1_data;
        logic [63:0] rs2_data;
        logic [63:0] alu;
        logic [63:0] mem_addr;
        logic [63:0] mem_wdata;
        logic [63:0] mem_rdata;
        logic [63:0] rd_data;
        logic [63:0] npc;
        logic [4:0]  rs1_id;
        logic [4:0]  rs2_id;
        logic [4:0]  rd_id;
        logic        mem_we;
        logic        rd_we;
        logic        br_taken;
    } core_info_t;

    typedef struct packed {
        logic [63:0] uart_info;
    } mem_info_t;

    // board switch bank, sw15 first
    typedef struct packed {
        logic         debug_step;
        logic         slow_clock;
        logic [7:0]   unused;
        logic         word_half;
        trace_field_e field_sel;
    } panel_switch_t;

    function automatic seg_pattern_t hex_to_segments(input logic [3:0] hex);
        case (hex)
            4'h0: return 8'b11000000;
            4'h1: return 8'b11111001;
            4'h2: return 8'b10100100;
            4'h3: return 8'b10110000;
            4'h4: return 8'b10011001;
            4'h5: return 8'b10010010;
            4'h6: return 8'b10000010;
            4'h7: return 8'b11111000;
            4'h8: return 8'b10000000;
            4'h9: return 8'b10010000;
            4'ha: return 8'b10001000;
            4'hb: return 8'b10000011;
            4'hc: return 8'b11000110;
            4'hd: return 8'b10100001;
            4'he: return 8'b10000110;
            default: return 8'b10001110;
        endcase
    endfunction

endpackage

`default_nettype wire

/* seg_scan_display.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_scan_display (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             scan_tick,
    input  logic [io_pkg::DISPLAY_WIDTH-1:0] display_word,
    output io_pkg::seg_pattern_t             cs,
    output io_pkg::digit_enable_t            an
);

    localparam int ND = io_pkg::NUM_DIGITS;

    io_pkg::digit_enable_t an_q;
    logic [3:0]            digit_nibble;

    // single low bit walks towards the top digit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            an_q <= {{(ND-1){1'b1}}, 1'b0};
        end else if (scan_tick) begin
            an_q <= {an_q[ND-2:0], an_q[ND-1]};
        end
    end

    // nibble of the enabled digit, digit k shows bits 4k+3..4k
    always_comb begin
        digit_nibble = 4'h0;
        for (int k = 0; k < ND; k++) begin
            if (!an_q[k]) begin
                digit_nibble = display_word[4*k +: 4];
            end
        end
    end

    assign cs = io_pkg::hex_to_segments(digit_nibble);
    assign an = an_q;

endmodule

`default_nettype wire

/* tb_debug_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_debug_io;

    localparam int FAST_CLK_BIT   = 1;
    localparam int SLOW_CLK_BIT   = 4;
    localparam int SCAN_DIV_BITS  = 2;
    localparam int DEBOUNCE_LEN   = 4;
    localparam int TIMEOUT_CYCLES = 4000;

    // board segment table, indexed by hex digit
    localparam io_pkg::seg_pattern_t SEG_TABLE [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    logic                           clk;
    logic                           rst;
    io_pkg::panel_switch_t          switch;
    logic [io_pkg::NUM_BUTTONS-1:0] btn;
    logic                           cosim_valid;
    io_pkg::core_info_t             cosim_core_info;
    io_pkg::mem_info_t              cosim_mem_info;
    logic                           clk_core;
    io_pkg::seg_pattern_t           cs;
    io_pkg::digit_enable_t          an;

    logic [31:0]        lfsr_state;
    // posedges since reset release, tracks the divider counter
    logic [31:0]        run_cycles = '0;
    int                 cycle_count = 0;
    io_pkg::core_info_t core_rec;
    io_pkg::mem_info_t  mem_rec;

    debug_io_top #(
        .FAST_CLK_BIT  (FAST_CLK_BIT),
        .SLOW_CLK_BIT  (SLOW_CLK_BIT),
        .SCAN_DIV_BITS (SCAN_DIV_BITS),
        .DEBOUNCE_LEN  (DEBOUNCE_LEN)
    ) UUT (
        .clk             (clk),
        .rst             (rst),
        .switch          (switch),
        .btn             (btn),
        .cosim_valid     (cosim_valid),
        .cosim_core_info (cosim_core_info),
        .cosim_mem_info  (cosim_mem_info),
        .clk_core        (clk_core),
        .cs              (cs),
        .an              (an)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (rst) begin
            run_cycles = '0;
        end else begin
            run_cycles = run_cycles + 32'd1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_segments(input string name, input io_pkg::seg_pattern_t exp,
                                  input io_pkg::seg_pattern_t got);
        if (got !== exp) begin
            report_fail($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_enable(input string name, input io_pkg::digit_enable_t exp,
                                input io_pkg::digit_enable_t got);
        if (got !== exp) begin
            report_fail($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            report_fail($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp, got));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    task automatic random_record(output io_pkg::core_info_t rec, output io_pkg::mem_info_t mem);
        rec = '0;
        mem = '0;
        for (int i = 0; i < $bits(io_pkg::core_info_t); i++) begin
            rec[i] = next_bit();
        end
        for (int i = 0; i < $bits(io_pkg::mem_info_t); i++) begin
            mem[i] = next_bit();
        end
    endtask

    // 64-bit trace word for a selector, narrow fields zero extended
    function automatic logic [63:0] field_word(input io_pkg::core_info_t rec,
                                               input io_pkg::mem_info_t mem, input int sel);
        case (sel)
            0:       return rec.pc;
            1:       return rec.inst;
            2:       return 64'(rec.rs1_id);
            3:       return rec.rs1_data;
            4:       return 64'(rec.rs2_id);
            5:       return rec.rs2_data;
            6:       return rec.alu;
            7:       return rec.mem_addr;
            8:       return 64'(rec.mem_we);
            9:       return rec.mem_wdata;
            10:      return rec.mem_rdata;
            11:      return 64'(rec.rd_we);
            12:      return 64'(rec.rd_id);
            13:      return rec.rd_data;
            14:      return 64'(rec.br_taken);
            15:      return rec.npc;
            16:      return mem.uart_info;
            default: return 64'h0;
        endcase
    endfunction

    task automatic drive_edge();
        @(posedge clk);
        #1;
    endtask

    // first cycle after the next scan strobe
    task automatic wait_tick();
        @(negedge clk);
        while (run_cycles[SCAN_DIV_BITS-1:0] != '0) begin
            @(negedge clk);
        end
    endtask

    // clk_core low on every cycle up to the next strobe
    task automatic hold_low_to_tick();
        @(negedge clk);
        check_bit("clk_core", 1'b0, clk_core);
        while (run_cycles[SCAN_DIV_BITS-1:0] != '0) begin
            @(negedge clk);
            check_bit("clk_core", 1'b0, clk_core);
        end
    endtask

    task automatic select_field(input int sel, input logic half);
        drive_edge();
        switch.field_sel = io_pkg::trace_field_e'(sel[4:0]);
        switch.word_half = half;
    endtask

    task automatic load_record(input io_pkg::core_info_t rec, input io_pkg::mem_info_t mem);
        drive_edge();
        cosim_core_info = rec;
        cosim_mem_info  = mem;
        cosim_valid     = 1'b1;
        drive_edge();
        cosim_valid = 1'b0;
    endtask

    // one digit per strobe, all eight positions
    task automatic check_display(input logic [31:0] word);
        int pos;
        for (int k = 0; k < io_pkg::NUM_DIGITS; k++) begin
            wait_tick();
            pos = int'(run_cycles[SCAN_DIV_BITS +: 3]);
            check_enable("an", ~(8'b1 << pos), an);
            check_segments("cs", SEG_TABLE[word[4*pos +: 4]], cs);
        end
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_enable("an", 8'b11111110, an);
        check_segments("cs", 8'b11000000, cs);
    endtask

    task automatic test_fields();
        logic [63:0] w;
        random_record(core_rec, mem_rec);
        load_record(core_rec, mem_rec);
        for (int sel = 0; sel <= 16; sel++) begin
            select_field(sel, 1'b0);
            w = field_word(core_rec, mem_rec, sel);
            check_display(w[31:0]);
        end
    endtask

    task automatic test_half_and_unused();
        select_field(0, 1'b1);
        check_display(core_rec.pc[63:32]);
        for (int sel = 17; sel <= 31; sel++) begin
            select_field(sel, sel[0]);
            check_display(32'h0);
        end
        select_field(16, 1'b1);
        check_display(mem_rec.uart_info[63:32]);
    endtask

    task automatic test_capture_hold();
        io_pkg::core_info_t next_rec;
        io_pkg::mem_info_t  next_mem;
        random_record(next_rec, next_mem);
        drive_edge();
        cosim_core_info = next_rec;
        cosim_mem_info  = next_mem;
        select_field(0, 1'b0);
        check_display(core_rec.pc[31:0]);
        load_record(next_rec, next_mem);
        check_display(next_rec.pc[31:0]);
        core_rec = next_rec;
        mem_rec  = next_mem;
    endtask

    task automatic test_divided_clock();
        drive_edge();
        switch.slow_clock = 1'b0;
        repeat (40) begin
            @(negedge clk);
            check_bit("clk_core", run_cycles[FAST_CLK_BIT], clk_core);
        end
        drive_edge();
        switch.slow_clock = 1'b1;
        repeat (80) begin
            @(negedge clk);
            check_bit("clk_core", run_cycles[SLOW_CLK_BIT], clk_core);
        end
        drive_edge();
        switch.slow_clock = 1'b0;
    endtask

    task automatic test_single_step();
        drive_edge();
        switch.debug_step = 1'b1;
        // debug register picks up the switch on this edge
        drive_edge();
        hold_low_to_tick();
        // short press, one strobe too few
        drive_edge();
        btn[0] = 1'b1;
        repeat (DEBOUNCE_LEN - 1) begin
            hold_low_to_tick();
        end
        drive_edge();
        btn[0] = 1'b0;
        hold_low_to_tick();
        drive_edge();
        btn[0] = 1'b1;
        repeat (DEBOUNCE_LEN - 1) begin
            hold_low_to_tick();
        end
        wait_tick();
        check_bit("clk_core", 1'b1, clk_core);
        drive_edge();
        btn[0] = 1'b0;
        wait_tick();
        check_bit("clk_core", 1'b0, clk_core);
        drive_edge();
        switch.debug_step = 1'b0;
    endtask

    initial begin
        lfsr_state      = 32'h272bc288;
        rst             = 1'b1;
        switch          = '0;
        btn             = '0;
        cosim_valid     = 1'b0;
        cosim_core_info = '0;
        cosim_mem_info  = '0;
        test_reset();
        test_fields();
        test_half_and_unused();
        test_capture_hold();
        test_divided_clock();
        test_single_step();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* trace_select.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_select (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cosim_valid,
    input  io_pkg::core_info_t                 cosim_core_info,
    input  io_pkg::mem_info_t                  cosim_mem_info,
    input  io_pkg::trace_field_e               field_sel,
    input  logic                               word_half,
    output logic [io_pkg::DISPLAY_WIDTH-1:0]   display_word
);

    localparam int TW = io_pkg::TRACE_WIDTH;
    localparam int DW = io_pkg::DISPLAY_WIDTH;

    io_pkg::core_info_t core_q;
    io_pkg::mem_info_t  mem_q;
    logic [TW-1:0]      trace_word;

    // both records latched together on each valid commit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            core_q <= '0;
            mem_q  <= '0;
        end else if (cosim_valid) begin
            core_q <= cosim_core_info;
            mem_q  <= cosim_mem_info;
        end
    end

    // narrow fields are zero extended
    always_comb begin
        case (field_sel)
            io_pkg::FIELD_PC:        trace_word = core_q.pc;
            io_pkg::FIELD_INST:      trace_word = core_q.inst;
            io_pkg::FIELD_RS1_ID:    trace_word = {{(TW-5){1'b0}}, core_q.rs1_id};
            io_pkg::FIELD_RS1_DATA:  trace_word = core_q.rs1_data;
            io_pkg::FIELD_RS2_ID:    trace_word = {{(TW-5){1'b0}}, core_q.rs2_id};
            io_pkg::FIELD_RS2_DATA:  trace_word = core_q.rs2_data;
            io_pkg::FIELD_ALU:       trace_word = core_q.alu;
            io_pkg::FIELD_MEM_ADDR:  trace_word = core_q.mem_addr;
            io_pkg::FIELD_MEM_WE:    trace_word = {{(TW-1){1'b0}}, core_q.mem_we};
            io_pkg::FIELD_MEM_WDATA: trace_word = core_q.mem_wdata;
            io_pkg::FIELD_MEM_RDATA: trace_word = core_q.mem_rdata;
            io_pkg::FIELD_RD_WE:     trace_word = {{(TW-1){1'b0}}, core_q.rd_we};
            io_pkg::FIELD_RD_ID:     trace_word = {{(TW-5){1'b0}}, core_q.rd_id};
            io_pkg::FIELD_RD_DATA:   trace_word = core_q.rd_data;
            io_pkg::FIELD_BR_TAKEN:  trace_word = {{(TW-1){1'b0}}, core_q.br_taken};
            io_pkg::FIELD_NPC:       trace_word = core_q.npc;
            io_pkg::FIELD_UART:      trace_word = mem_q.uart_info;
            // unnamed selectors
            default:                 trace_word = '0;
        endcase
    end

    // upper or lower half of the chosen word
    assign display_word = word_half ? trace_word[TW-1:TW-DW] : trace_word[DW-1:0];

endmodule

`default_nettype wire
